//--- project.f
src/genbus_pkg.sv
src/mbus_if.sv
src/mbus_arbiter.sv
src/zbus_arbiter.sv
src/z80_bus_ctrl.sv
src/genbus_top.sv
testbench/tb_genbus.sv

//--- Bender.yml
package:
  name: genbus

sources:
  - src/genbus_pkg.sv
  - src/mbus_if.sv
  - src/mbus_arbiter.sv
  - src/zbus_arbiter.sv
  - src/z80_bus_ctrl.sv
  - src/genbus_top.sv
  - target: simulation
    files:
      - testbench/tb_genbus.sv

//--- testbench/tb_genbus.sv
// System bus controller testbench
`timescale 1ns/1ns

module tb_genbus;

	localparam int CLK_PERIOD   = 40;
	localparam int ACCESS_COUNT = 100;
	localparam int TIMEOUT_NS   = 200 * ACCESS_COUNT * CLK_PERIOD;

	logic        MCLK;
	logic        reset;
	logic [23:1] m68k_a;
	logic [15:0] m68k_do;
	logic        m68k_as_n;
	logic        m68k_uds_n;
	logic        m68k_lds_n;
	logic        m68k_rnw;
	logic [15:0] m68k_di;
	logic        m68k_dtack_n;
	logic [15:0] z80_a;
	logic [7:0]  z80_do;
	logic        z80_mreq_n;
	logic        z80_rd_n;
	logic        z80_wr_n;
	logic        z80_busak_n;
	logic [7:0]  z80_di;
	logic        z80_wait_n;
	logic        z80_busrq_n;
	logic        z80_reset_n;
	logic [23:1] va;
	logic [15:0] vdo;
	logic        bus_rnw;
	logic        uds_n;
	logic        lds_n;
	logic        asel_n;
	logic        wrl_n;
	logic        wrh_n;
	logic        oe_n;
	logic        ram_ce_n;
	logic [15:0] vdi;
	logic        dtack_n;
	logic        ram_rdy;

	logic [31:0] lfsr;
	logic [15:0] rom_q;
	logic [15:0] ram_mem [0:255];
	logic [1:0]  busrq_pipe;
	int          rom_cnt;
	int          ram_ph;
	int          ram_gap;
	int          error_count;

	genbus_top u_genbus_top (.*);

	// Fibonacci LFSR stepped once per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			r    = {r[30:0], fb};
		end
		return r;
	endfunction

	task automatic check_value(input string name, input logic [23:0] got,
		input logic [23:0] exp);
		assert (got === exp) else begin
			error_count++;
			$display("ERROR %0t ns %s got %h expected %h", $time, name, got, exp);
			$display("CHECKS FAILED");
			$fatal(1);
		end
	endtask

	task automatic fail_plain(input string msg);
		error_count++;
		$display("%0t ns %s", $time, msg);
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	initial begin
		MCLK = 1'b0;
		forever #(CLK_PERIOD / 2) MCLK = ~MCLK;
	end

	initial begin
		#(TIMEOUT_NS);
		fail_plain("Watchdog expired, a bus access never completed");
	end

	// ----------------------------------------------------------------------
	// Slave and Z80 models
	// ----------------------------------------------------------------------

	assign vdi = !ram_ce_n ? ram_mem[va[8:1]] : rom_q;

	// ROM answers 0-3 cycles after its select
	initial begin
		forever begin
			@(posedge MCLK);
			#2;
			if (asel_n) begin
				dtack_n = 1'b1;
				rom_cnt = -1;
			end else if (dtack_n) begin
				if (rom_cnt < 0) begin
					rom_cnt = rand_bits(2);
				end else if (rom_cnt == 0) begin
					rom_q   = va[16:1] + 16'h1234;
					dtack_n = 1'b0;
				end else begin
					rom_cnt--;
				end
			end
		end
	end

	// RAM model drops ram_rdy to accept and raises it to complete
	initial begin
		forever begin
			@(posedge MCLK);
			#2;
			if (ram_ce_n) begin
				ram_ph  = 0;
				ram_rdy = 1'b1;
			end else if (ram_ph == 0) begin
				ram_gap = rand_bits(2);
				ram_ph  = 1;
			end else if (ram_gap > 0) begin
				ram_gap--;
			end else if (ram_ph == 1) begin
				ram_rdy = 1'b0;
				if (!wrh_n) ram_mem[va[8:1]][15:8] = vdo[15:8];
				if (!wrl_n) ram_mem[va[8:1]][7:0] = vdo[7:0];
				ram_gap = rand_bits(2);
				ram_ph  = 2;
			end else if (ram_ph == 2) begin
				ram_rdy = 1'b1;
				ram_ph  = 3;
			end
		end
	end

	// Bus acknowledge lags the request by 2 cycles
	initial begin
		forever begin
			@(posedge MCLK);
			#2;
			z80_busak_n = busrq_pipe[1];
			busrq_pipe  = {busrq_pipe[0], z80_busrq_n};
		end
	end

	// RAM select and write strobes against the 68000 cycle
	always @(negedge MCLK) begin
		if (!reset && !ram_ce_n) begin
			assert (!m68k_as_n || !m68k_dtack_n) else
				fail_plain("ram_ce_n is low outside of a 68000 access");
			if (!m68k_as_n) begin
				check_value("wrl_n", wrl_n, m68k_rnw | m68k_lds_n);
				check_value("wrh_n", wrh_n, m68k_rnw | m68k_uds_n);
				check_value("uds_n", uds_n, m68k_uds_n);
				check_value("lds_n", lds_n, m68k_lds_n);
				check_value("oe_n", oe_n, !m68k_rnw);
			end
		end
	end

	// ----------------------------------------------------------------------
	// Bus cycles
	// ----------------------------------------------------------------------

	task automatic m68k_cycle(input logic [23:0] byte_addr, input logic [15:0] wdata,
		input logic rnw, input logic uds, input logic lds, output logic [15:0] rdata,
		output time done_at);
		@(posedge MCLK);
		#2;
		m68k_a     = byte_addr[23:1];
		m68k_do    = wdata;
		m68k_rnw   = rnw;
		m68k_uds_n = uds;
		m68k_lds_n = lds;
		m68k_as_n  = 1'b0;
		do @(negedge MCLK); while (m68k_dtack_n);
		rdata   = m68k_di;
		done_at = $time;
		@(posedge MCLK);
		#2;
		check_value("m68k_dtack_n", m68k_dtack_n, 1'b0);
		m68k_as_n  = 1'b1;
		m68k_uds_n = 1'b1;
		m68k_lds_n = 1'b1;
		m68k_rnw   = 1'b1;
		@(negedge MCLK);
		@(negedge MCLK);
		check_value("m68k_dtack_n", m68k_dtack_n, 1'b1);
	endtask

	task automatic z80_cycle(input logic [15:0] addr, input logic [7:0] wdata,
		input logic wr, output logic [7:0] rdata, output logic [23:1] va_seen,
		output time done_at);
		@(posedge MCLK);
		#2;
		z80_a      = addr;
		z80_do     = wdata;
		z80_rd_n   = wr;
		z80_wr_n   = !wr;
		z80_mreq_n = 1'b0;
		do @(negedge MCLK); while (!z80_wait_n);
		rdata   = z80_di;
		va_seen = va;
		done_at = $time;
		@(posedge MCLK);
		#2;
		z80_mreq_n = 1'b1;
		z80_rd_n   = 1'b1;
		z80_wr_n   = 1'b1;
	endtask

	// ----------------------------------------------------------------------
	// Test sequence
	// ----------------------------------------------------------------------

	initial begin
		logic [15:0] rd;
		logic [7:0]  zd;
		logic [23:1] vs;
		logic [15:0] offs [0:7];
		logic [7:0]  bytes [0:7];
		logic [8:0]  bank_exp;
		logic [15:0] zoff;
		logic [15:0] word;
		logic        bit_in;
		logic [31:0] rnd;
		logic [23:1] va_exp;
		time         t68;
		time         tz;
		int          polls;

		lfsr        = 32'd82634;
		error_count = 0;
		reset       = 1'b1;
		m68k_a      = '0;
		m68k_do     = '0;
		m68k_as_n   = 1'b1;
		m68k_uds_n  = 1'b1;
		m68k_lds_n  = 1'b1;
		m68k_rnw    = 1'b1;
		z80_a       = '0;
		z80_do      = '0;
		z80_mreq_n  = 1'b1;
		z80_rd_n    = 1'b1;
		z80_wr_n    = 1'b1;
		z80_busak_n = 1'b1;
		busrq_pipe  = 2'b11;
		dtack_n     = 1'b1;
		ram_rdy     = 1'b1;
		rom_q       = '0;
		rom_cnt     = -1;
		ram_ph      = 0;
		ram_gap     = 0;
		repeat (2) @(posedge MCLK);
		#2;
		reset = 1'b0;
		@(negedge MCLK);
		check_value("m68k_dtack_n", m68k_dtack_n, 1'b1);
		check_value("ram_ce_n", ram_ce_n, 1'b1);
		check_value("z80_reset_n", z80_reset_n, 1'b0);
		check_value("bus_rnw", bus_rnw, 1'b1);
		check_value("z80_wait_n", z80_wait_n, 1'b1);
		check_value("z80_busrq_n", z80_busrq_n, 1'b1);
		check_value("uds_n", uds_n, 1'b1);
		check_value("lds_n", lds_n, 1'b1);
		check_value("wrl_n", wrl_n, 1'b1);
		check_value("wrh_n", wrh_n, 1'b1);
		check_value("asel_n", asel_n, 1'b1);

		// Open bus after reset, then the last 68000 read
		m68k_cycle(24'h800000, 16'h0, 1'b1, 1'b0, 1'b0, rd, t68);
		check_value("m68k_di", rd, 16'h4E71);
		m68k_cycle(24'h001230, 16'h0, 1'b1, 1'b0, 1'b0, rd, t68);
		check_value("m68k_di", rd, 16'h0918 + 16'h1234);
		m68k_cycle(24'h900002, 16'h0, 1'b1, 1'b0, 1'b0, rd, t68);
		check_value("m68k_di", rd, 16'h0918 + 16'h1234);

		// Take the Z80 bus
		m68k_cycle(24'hA11100, 16'h0100, 1'b0, 1'b0, 1'b0, rd, t68);
		m68k_cycle(24'hA11200, 16'h0100, 1'b0, 1'b0, 1'b0, rd, t68);
		polls = 0;
		do begin
			m68k_cycle(24'hA11100, 16'h0, 1'b1, 1'b0, 1'b0, rd, t68);
			polls++;
		end while (rd[8] && polls < 20);
		assert (!rd[8]) else fail_plain("Z80 bus grant never read back");

		for (int i = 0; i < 8; i++) begin
			rnd      = rand_bits(6);
			offs[i]  = {7'd0, rnd[5:0], i[2:0]};
			rnd      = rand_bits(8);
			bytes[i] = rnd[7:0];
			m68k_cycle(24'hA00000 + offs[i], {bytes[i], bytes[i]}, 1'b0,
				offs[i][0], !offs[i][0], rd, t68);
		end
		for (int i = 0; i < 8; i++) begin
			m68k_cycle(24'hA00000 + offs[i], 16'h0, 1'b1, offs[i][0], !offs[i][0], rd, t68);
			check_value("m68k_di lane", offs[i][0] ? rd[7:0] : rd[15:8], bytes[i]);
		end

		// Writes are dropped and reads float with the bus released
		m68k_cycle(24'hA11100, 16'h0000, 1'b0, 1'b0, 1'b0, rd, t68);
		m68k_cycle(24'hA00000 + offs[0], ~{bytes[0], bytes[0]}, 1'b0,
			offs[0][0], !offs[0][0], rd, t68);
		m68k_cycle(24'hA00000 + offs[1], 16'h0, 1'b1, offs[1][0], !offs[1][0], rd, t68);
		check_value("m68k_di", rd, 16'hFFFF);
		m68k_cycle(24'hA04000, 16'h0, 1'b1, 1'b0, 1'b1, rd, t68);
		check_value("m68k_di", rd, 16'hFFFF);
		z80_cycle(16'h4001, 8'h0, 1'b0, zd, vs, tz);
		check_value("z80_di", zd, 8'hFF);
		for (int i = 0; i < 8; i++) begin
			z80_cycle(offs[i], 8'h0, 1'b0, zd, vs, tz);
			check_value("z80_di", zd, bytes[i]);
		end

		// Serial bank load, then banked ROM reads
		// The first bit written ends in bit 0 of the bank
		bank_exp = '0;
		for (int k = 0; k < 9; k++) begin
			if (k == 8) begin
				bit_in = 1'b0;
			end else begin
				rnd    = rand_bits(1);
				bit_in = rnd[0];
			end
			bank_exp[k] = bit_in;
			rnd = rand_bits(7);
			z80_cycle(16'h6000, {rnd[6:0], bit_in}, 1'b1, zd, vs, tz);
		end
		for (int i = 0; i < 4; i++) begin
			rnd    = rand_bits(15);
			zoff   = {1'b1, rnd[14:0]};
			va_exp = {bank_exp, zoff[14:1]};
			z80_cycle(zoff, 8'h0, 1'b0, zd, vs, tz);
			check_value("va", vs, va_exp);
			word = va_exp[16:1] + 16'h1234;
			check_value("z80_di", zd, zoff[0] ? word[7:0] : word[15:8]);
		end

		// Work RAM round trip
		for (int i = 0; i < 4; i++) begin
			rnd      = rand_bits(16);
			word     = rnd[15:0];
			rnd      = rand_bits(8);
			bytes[i] = rnd[7:0];
			m68k_cycle(24'hE00000 + {i[6:0], 1'b0}, word, 1'b0, 1'b0, 1'b0, rd, t68);
			m68k_cycle(24'hFF0000 + {i[6:0], 1'b0}, {8'h0, bytes[i]}, 1'b0, 1'b1, 1'b0,
				rd, t68);
			m68k_cycle(24'hE00000 + {i[6:0], 1'b0}, 16'h0, 1'b1, 1'b0, 1'b0, rd, t68);
			check_value("m68k_di", rd, {word[15:8], bytes[i]});
		end

		// Both masters in the same cycle
		fork
			m68k_cycle(24'h000100, 16'h0, 1'b1, 1'b0, 1'b0, rd, t68);
			z80_cycle(16'h8002, 8'h0, 1'b0, zd, vs, tz);
		join
		assert (t68 < tz) else fail_plain("Z80 cycle was served before the 68000 cycle");

		if (error_count == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

//--- src/genbus_top.sv
// Console system bus controller
`timescale 1ns/1ns

module genbus_top (
	input  logic        MCLK,
	input  logic        reset,
	// 68000 bus
	input  logic [23:1] m68k_a,
	input  logic [15:0] m68k_do,
	input  logic        m68k_as_n,
	input  logic        m68k_uds_n,
	input  logic        m68k_lds_n,
	input  logic        m68k_rnw,
	output logic [15:0] m68k_di,
	output logic        m68k_dtack_n,
	// Z80 bus
	input  logic [15:0] z80_a,
	input  logic [7:0]  z80_do,
	input  logic        z80_mreq_n,
	input  logic        z80_rd_n,
	input  logic        z80_wr_n,
	input  logic        z80_busak_n,
	output logic [7:0]  z80_di,
	output logic        z80_wait_n,
	output logic        z80_busrq_n,
	output logic        z80_reset_n,
	// External bus
	output logic [23:1] va,
	output logic [15:0] vdo,
	output logic        bus_rnw,
	output logic        uds_n,
	output logic        lds_n,
	output logic        asel_n,
	output logic        wrl_n,
	output logic        wrh_n,
	output logic        oe_n,
	output logic        ram_ce_n,
	input  logic [15:0] vdi,
	input  logic        dtack_n,
	input  logic        ram_rdy
);

	logic [genbus_pkg::BANK_W-1:0] bank;
	logic                          z80_zbus_hit;
	logic [7:0]                    z80_zbus_din;
	logic                          z80_zbus_dtack_n;
	logic                          zbus_free;

	mbus_if bus ();

	// ----------------------------------------------------------------------
	// Main bus
	// ----------------------------------------------------------------------

	mbus_arbiter u_mbus_arbiter (
		.MCLK, .reset,
		.m68k_a, .m68k_do, .m68k_as_n, .m68k_uds_n, .m68k_lds_n, .m68k_rnw,
		.m68k_di, .m68k_dtack_n,
		.z80_a, .z80_do, .z80_mreq_n, .z80_rd_n, .z80_wr_n,
		.z80_di, .z80_wait_n,
		.va, .vdo, .bus_rnw, .uds_n, .lds_n, .asel_n, .wrl_n, .wrh_n, .oe_n,
		.ram_ce_n, .vdi, .dtack_n, .ram_rdy,
		.bank, .z80_zbus_hit, .z80_zbus_din, .z80_zbus_dtack_n,
		.bus (bus.arbiter)
	);

	// Z80 side slaves
	zbus_arbiter u_zbus_arbiter (
		.MCLK, .reset,
		.bus (bus.slave),
		.zbus_free,
		.z80_a, .z80_do, .z80_mreq_n, .z80_rd_n, .z80_wr_n,
		.z80_zbus_hit, .z80_zbus_din, .z80_zbus_dtack_n,
		.bank
	);

	z80_bus_ctrl u_z80_bus_ctrl (
		.MCLK, .reset,
		.bus (bus.slave),
		.z80_busak_n,
		.z80_busrq_n,
		.z80_reset_n,
		.zbus_free
	);

endmodule

//--- src/z80_bus_ctrl.sv
// Z80 bus request and reset control
`timescale 1ns/1ns

module z80_bus_ctrl (
	input  logic  MCLK,
	input  logic  reset,
	mbus_if.slave bus,
	input  logic  z80_busak_n,
	output logic  z80_busrq_n,
	output logic  z80_reset_n,
	output logic  zbus_free
);

	logic ctrl_wr;
	logic ctrl_f;

	// Only the upper byte carries the control bit
	assign ctrl_wr = bus.ctrl_sel && !bus.rnw && !bus.uds_n;

	always_ff @(posedge MCLK) begin
		if (reset) begin
			z80_busrq_n <= 1'b1;
			z80_reset_n <= 1'b0;
		end else if (ctrl_wr) begin
			if (bus.a[11:8] == 4'd1) begin
				z80_busrq_n <= ~bus.dout[8];
			end
			if (bus.a[11:8] == 4'd2) begin
				z80_reset_n <= bus.dout[8];
			end
		end
	end

	// Readback bit, everything else floats
	always_comb begin
		case (bus.a[11:8])
			4'd1:    ctrl_f = z80_busak_n | ~z80_reset_n;
			4'd2:    ctrl_f = z80_reset_n;
			default: ctrl_f = bus.open_bus[8];
		endcase
	end

	assign bus.ctrl_din = {bus.open_bus[15:9], ctrl_f, bus.open_bus[7:0]};

	assign zbus_free = ~z80_busrq_n & z80_reset_n;

endmodule

//--- src/zbus_arbiter.sv
// Z80 bus arbiter with RAM and bank register
`timescale 1ns/1ns

module zbus_arbiter (
	input  logic        MCLK,
	input  logic        reset,
	mbus_if.slave       bus,
	input  logic        zbus_free,
	// Z80 bus
	input  logic [15:0] z80_a,
	input  logic [7:0]  z80_do,
	input  logic        z80_mreq_n,
	input  logic        z80_rd_n,
	input  logic        z80_wr_n,
	output logic        z80_zbus_hit,
	output logic [7:0]  z80_zbus_din,
	output logic        z80_zbus_dtack_n,
	output logic [genbus_pkg::BANK_W-1:0] bank
);

	genbus_pkg::zbus_state_t zstate;
	genbus_pkg::zbus_src_t   zsrc;

	logic                           z80_io;
	logic                           z80_zbus_sel;
	logic [genbus_pkg::ZBUS_AW-1:0] zbus_a;
	logic [7:0]                     zbus_do;
	logic                           zbus_we;
	logic [7:0]                     zbus_di;
	logic                           zram_sel;
	logic                           bank_sel;
	logic [7:0]                     zram_q;

	logic [7:0] zram [0:(2**genbus_pkg::ZRAM_AW)-1];

	// Z80 space 0000-7EFF stays local
	assign z80_io       = !z80_mreq_n && (!z80_rd_n || !z80_wr_n);
	assign z80_zbus_hit = !z80_a[15] && !(&z80_a[14:8]);
	assign z80_zbus_sel = z80_zbus_hit && z80_io;

	// ----------------------------------------------------------------------
	// Decode: RAM 0000-3FFF, FM 4000-5FFF, bank 6000-60FF
	// ----------------------------------------------------------------------

	assign zram_sel = ~zbus_a[14];
	assign bank_sel = (zbus_a[14:8] == 7'h60);

	// FM space and the rest read as idle
	assign zbus_di = zram_sel ? zram_q : genbus_pkg::FM_IDLE_DATA;

	always_ff @(posedge MCLK) begin
		if (zbus_we && zram_sel) begin
			zram[zbus_a[genbus_pkg::ZRAM_AW-1:0]] <= zbus_do;
		end
		zram_q <= zram[zbus_a[genbus_pkg::ZRAM_AW-1:0]];
	end

	// Serial load, one bit per write from the top
	always_ff @(posedge MCLK) begin
		if (reset) begin
			bank <= '0;
		end else if (bank_sel && zbus_we) begin
			bank <= {zbus_do[0], bank[genbus_pkg::BANK_W-1:1]};
		end
	end

	// ----------------------------------------------------------------------
	// Arbitration
	// ----------------------------------------------------------------------

	always_ff @(posedge MCLK) begin
		if (reset) begin
			zstate           <= genbus_pkg::zs_idle;
			zsrc             <= genbus_pkg::zsrc_mbus;
			zbus_we          <= 1'b0;
			bus.zbus_dtack_n <= 1'b1;
			z80_zbus_dtack_n <= 1'b1;
		end else begin
			zbus_we <= 1'b0;

			// Handshake drops once the requester lets go
			if (!bus.zbus_sel) begin
				bus.zbus_dtack_n <= 1'b1;
			end
			if (!z80_zbus_sel) begin
				z80_zbus_dtack_n <= 1'b1;
			end

			case (zstate)
				genbus_pkg::zs_idle: begin
					if (bus.zbus_sel && bus.zbus_dtack_n) begin
						// Byte lane picked by UDS
						zbus_a  <= {bus.a[14:1], bus.uds_n};
						zbus_do <= !bus.uds_n ? bus.dout[15:8] : bus.dout[7:0];
						zbus_we <= !bus.rnw && zbus_free;
						zsrc    <= genbus_pkg::zsrc_mbus;
						zstate  <= genbus_pkg::zs_read;
					end else if (z80_zbus_sel && z80_zbus_dtack_n) begin
						zbus_a  <= z80_a[14:0];
						zbus_do <= z80_do;
						zbus_we <= !z80_wr_n;
						zsrc    <= genbus_pkg::zsrc_z80;
						zstate  <= genbus_pkg::zs_read;
					end
				end

				genbus_pkg::zs_read: begin
					zstate <= genbus_pkg::zs_finish;
				end

				default: begin
					if (zsrc == genbus_pkg::zsrc_mbus) begin
						bus.zbus_din     <= zbus_free ? zbus_di : genbus_pkg::FM_IDLE_DATA;
						bus.zbus_dtack_n <= 1'b0;
					end else begin
						z80_zbus_din     <= zbus_di;
						z80_zbus_dtack_n <= 1'b0;
					end
					zstate <= genbus_pkg::zs_idle;
				end
			endcase
		end
	end

endmodule

//--- src/mbus_arbiter.sv
// Main bus arbiter and decoder
`timescale 1ns/1ns

module mbus_arbiter (
	input  logic        MCLK,
	input  logic        reset,
	// 68000 bus
	input  logic [23:1] m68k_a,
	input  logic [15:0] m68k_do,
	input  logic        m68k_as_n,
	input  logic        m68k_uds_n,
	input  logic        m68k_lds_n,
	input  logic        m68k_rnw,
	output logic [15:0] m68k_di,
	output logic        m68k_dtack_n,
	// Z80 bus
	input  logic [15:0] z80_a,
	input  logic [7:0]  z80_do,
	input  logic        z80_mreq_n,
	input  logic        z80_rd_n,
	input  logic        z80_wr_n,
	output logic [7:0]  z80_di,
	output logic        z80_wait_n,
	// External slaves
	output logic [23:1] va,
	output logic [15:0] vdo,
	output logic        bus_rnw,
	output logic        uds_n,
	output logic        lds_n,
	output logic        asel_n,
	output logic        wrl_n,
	output logic        wrh_n,
	output logic        oe_n,
	output logic        ram_ce_n,
	input  logic [15:0] vdi,
	input  logic        dtack_n,
	input  logic        ram_rdy,
	// From the Z80 bus arbiter
	input  logic [genbus_pkg::BANK_W-1:0] bank,
	input  logic        z80_zbus_hit,
	input  logic [7:0]  z80_zbus_din,
	input  logic        z80_zbus_dtack_n,
	mbus_if.arbiter     bus
);

	genbus_pkg::mbus_state_t state;
	genbus_pkg::mbus_src_t   msrc;

	logic        z80_io;
	logic        z80_mbus_dtack_n;
	logic        rom_sel;
	logic        ram_sel;
	logic        done;
	logic        master_gone;
	logic [15:0] mbus_di;

	assign z80_io = !z80_mreq_n && (!z80_rd_n || !z80_wr_n);

	// Slave completion per wait state
	always_comb begin
		case (state)
			genbus_pkg::ms_rom_read:  done = !dtack_n;
			genbus_pkg::ms_ram_read:  done = ram_rdy;
			genbus_pkg::ms_ram_write: done = 1'b1;
			genbus_pkg::ms_zbus_read: done = !bus.zbus_dtack_n;
			genbus_pkg::ms_not_used:  done = 1'b1;
			default:                  done = 1'b0;
		endcase
	end

	assign master_gone =
		(msrc == genbus_pkg::src_m68k && m68k_as_n && !m68k_dtack_n) ||
		(msrc == genbus_pkg::src_z80 && !z80_io && !z80_mbus_dtack_n);

	// ----------------------------------------------------------------------
	// Cycle FSM
	// ----------------------------------------------------------------------

	always_ff @(posedge MCLK) begin
		if (reset) begin
			state            <= genbus_pkg::ms_idle;
			msrc             <= genbus_pkg::src_none;
			m68k_dtack_n     <= 1'b1;
			z80_mbus_dtack_n <= 1'b1;
			bus.rnw          <= 1'b1;
			bus.uds_n        <= 1'b1;
			bus.lds_n        <= 1'b1;
			asel_n           <= 1'b1;
			rom_sel          <= 1'b0;
			ram_sel          <= 1'b0;
			bus.zbus_sel     <= 1'b0;
			bus.ctrl_sel     <= 1'b0;
			bus.open_bus     <= genbus_pkg::OPEN_BUS_INIT;
		end else begin
			case (state)
				genbus_pkg::ms_idle: begin
					msrc <= genbus_pkg::src_none;
					if (!m68k_as_n && (!m68k_uds_n || !m68k_lds_n) && m68k_dtack_n) begin
						msrc      <= genbus_pkg::src_m68k;
						bus.a     <= m68k_a;
						bus.dout  <= m68k_do;
						bus.uds_n <= m68k_uds_n;
						bus.lds_n <= m68k_lds_n;
						bus.rnw   <= m68k_rnw;
						asel_n    <= m68k_a[23];
						state     <= genbus_pkg::ms_select;
					end else if (z80_io && !z80_zbus_hit && z80_mbus_dtack_n) begin
						msrc      <= genbus_pkg::src_z80;
						// Banked window or the C000xx page
						bus.a     <= z80_a[15] ? {bank, z80_a[14:1]} : {16'hC000, z80_a[7:1]};
						bus.dout  <= {z80_do, z80_do};
						bus.uds_n <= z80_a[0];
						bus.lds_n <= ~z80_a[0];
						bus.rnw   <= z80_wr_n;
						asel_n    <= z80_a[15] ? bank[8] : 1'b1;
						state     <= genbus_pkg::ms_select;
					end
				end

				genbus_pkg::ms_select: begin
					// Unmapped and control both finish from not_used
					state <= genbus_pkg::ms_not_used;
					if (!bus.a[23]) begin
						rom_sel <= 1'b1;
						state   <= genbus_pkg::ms_rom_read;
					end else if (bus.a[23:16] == 8'hA0) begin
						bus.zbus_sel <= 1'b1;
						state        <= genbus_pkg::ms_zbus_read;
					end else if (bus.a[23:12] == 12'hA11 && bus.a[7:1] == 7'd0) begin
						bus.ctrl_sel <= 1'b1;
					end else if (&bus.a[23:21]) begin
						ram_sel <= 1'b1;
						state   <= genbus_pkg::ms_ram_wait;
					end
				end

				genbus_pkg::ms_ram_wait: begin
					if (!ram_rdy) begin
						state <= bus.rnw ? genbus_pkg::ms_ram_read : genbus_pkg::ms_ram_write;
					end
				end

				genbus_pkg::ms_finish: begin
					if (master_gone) begin
						m68k_dtack_n     <= 1'b1;
						z80_mbus_dtack_n <= 1'b1;
						bus.rnw          <= 1'b1;
						bus.uds_n        <= 1'b1;
						bus.lds_n        <= 1'b1;
						asel_n           <= 1'b1;
						rom_sel          <= 1'b0;
						ram_sel          <= 1'b0;
						bus.zbus_sel     <= 1'b0;
						bus.ctrl_sel     <= 1'b0;
						state            <= genbus_pkg::ms_idle;
						if (msrc == genbus_pkg::src_m68k) begin
							bus.open_bus <= mbus_di;
						end
					end
				end

				default: begin
					if (done) begin
						m68k_dtack_n     <= (msrc != genbus_pkg::src_m68k);
						z80_mbus_dtack_n <= (msrc != genbus_pkg::src_z80);
						state            <= genbus_pkg::ms_finish;
					end
				end
			endcase
		end
	end

	// ----------------------------------------------------------------------
	// Read data and external strobes
	// ----------------------------------------------------------------------

	always_comb begin
		if (rom_sel || ram_sel) begin
			mbus_di = vdi;
		end else if (bus.zbus_sel) begin
			mbus_di = {bus.zbus_din, bus.zbus_din};
		end else if (bus.ctrl_sel) begin
			mbus_di = bus.ctrl_din;
		end else begin
			mbus_di = bus.open_bus;
		end
	end

	assign m68k_di = mbus_di;

	// Local Z80 RAM answers win over the main bus lane
	assign z80_di = !z80_zbus_dtack_n ? z80_zbus_din :
		(z80_a[0] ? mbus_di[7:0] : mbus_di[15:8]);
	assign z80_wait_n = !z80_io || !z80_mbus_dtack_n || !z80_zbus_dtack_n;

	assign va       = bus.a;
	assign vdo      = bus.dout;
	assign bus_rnw  = bus.rnw;
	assign uds_n    = bus.uds_n;
	assign lds_n    = bus.lds_n;
	assign ram_ce_n = ~ram_sel;
	assign wrl_n    = bus.rnw | bus.lds_n;
	assign wrh_n    = bus.rnw | bus.uds_n;
	assign oe_n     = ~bus.rnw;

endmodule

//--- src/mbus_if.sv
// Main bus slave interface
`timescale 1ns/1ns

interface mbus_if;

	// Latched cycle from the arbiter
	logic [genbus_pkg::MBUS_AW:1]   a;
	logic [genbus_pkg::MBUS_DW-1:0] dout;
	logic                           rnw;
	logic                           uds_n;
	logic                           lds_n;
	logic                           zbus_sel;
	logic                           ctrl_sel;
	logic [genbus_pkg::MBUS_DW-1:0] open_bus;

	// Slave returns
	logic [7:0]                     zbus_din;
	logic                           zbus_dtack_n;
	logic [genbus_pkg::MBUS_DW-1:0] ctrl_din;

	modport arbiter (
		output a, dout, rnw, uds_n, lds_n, zbus_sel, ctrl_sel, open_bus,
		input  zbus_din, zbus_dtack_n, ctrl_din
	);

	modport slave (
		input  a, dout, rnw, uds_n, lds_n, zbus_sel, ctrl_sel, open_bus,
		output zbus_din, zbus_dtack_n, ctrl_din
	);

endinterface

//--- src/genbus_pkg.sv
// Console system bus definitions
package genbus_pkg;

	// ----------------------------------------------------------------------
	// Bus widths
	// ----------------------------------------------------------------------

	// Main bus word address, bits 23:1
	localparam int MBUS_AW = 23;
	localparam int MBUS_DW = 16;

	// Z80 side
	localparam int ZBUS_AW = 15;
	localparam int ZRAM_AW = 13;
	localparam int BANK_W  = 9;

	// ----------------------------------------------------------------------
	// Reset and idle values
	// ----------------------------------------------------------------------

	// NOP opcode, what the bus floats to after power-up
	localparam logic [MBUS_DW-1:0] OPEN_BUS_INIT = 16'h4E71;

	// Empty Z80 space and FM reads
	localparam logic [7:0] FM_IDLE_DATA = 8'hFF;

	// ----------------------------------------------------------------------
	// State machines
	// ----------------------------------------------------------------------

	typedef enum logic [3:0] {
		ms_idle,
		ms_select,
		ms_ram_wait,
		ms_ram_read,
		ms_ram_write,
		ms_rom_read,
		ms_zbus_read,
		ms_not_used,
		ms_finish
	} mbus_state_t;

	// Master that owns the current main bus cycle
	typedef enum logic [1:0] {
		src_none,
		src_m68k,
		src_z80
	} mbus_src_t;

	typedef enum logic [1:0] {
		zs_idle,
		zs_read,
		zs_finish
	} zbus_state_t;

	// Owner of the Z80 RAM port
	typedef enum logic {
		zsrc_mbus,
		zsrc_z80
	} zbus_src_t;

endpackage
